//--- rtl/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// data path and address width.
`define RV_XLEN 32

// rv32e has sixteen integer registers.
`define RV_NUM_REGS 16
`define RV_REG_AW 4

// first instruction fetch address after reset.
`define RV_RESET_PC 32'h0000_0000

// every supported instruction is 32 bits wide.
`define RV_ILEN 32

`endif

//--- rtl/rv_core_pkg.sv
`default_nettype none

`include "rv_core_defines.svh"

package rv_core_pkg;

  // **************************************************************************
  // encodings
  // **************************************************************************

  // major opcodes, inst[6:0].
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  // the encoding is {funct7[5], funct3}, so decode can build it straight from the fields.
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,
    ST_FULL
  } fetch_state_e;

  // **************************************************************************
  // stage records
  // **************************************************************************

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_ILEN-1:0] inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   op1;
    logic [`RV_XLEN-1:0]   op2;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_REG_AW-1:0] rd;
    logic                  wen;
    alu_op_e               alu_op;
    logic [2:0]            br_kind;
    logic                  is_jump;
    logic                  is_branch;
    logic                  illegal;
  } decode_pkt_t;

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   data;
    logic                  wen;
    logic                  illegal;
  } retire_t;

endpackage

`default_nettype wire

//--- rtl/rv_fetch.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_fetch (
  input  wire                    clk,
  input  wire                    rst,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic [`RV_XLEN-1:0]    wb_adr_o,
  input  wire  [`RV_XLEN-1:0]    wb_dat_i,
  input  wire                    wb_ack_i,
  input  rv_core_pkg::redirect_t redirect_i,
  output logic                   f_valid_o,
  output rv_core_pkg::fetch_pkt_t f_pkt_o,
  input  wire                    f_ready_i
);
  import rv_core_pkg::*;

  fetch_state_e        state_q;
  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] adr_q;
  logic                discard_q;
  fetch_pkt_t          slot_q;
  logic                start_bus;
  logic                keep;

  // a bus cycle opens from idle, or once decode takes the slot.
  assign start_bus = !redirect_i.valid &&
                     ((state_q == ST_IDLE) || (state_q == ST_FULL && f_ready_i));
  // an ack is kept unless a redirect arrived during the cycle or on its edge.
  assign keep = (state_q == ST_BUS) && wb_ack_i && !discard_q && !redirect_i.valid;

  assign wb_cyc_o  = (state_q == ST_BUS);
  assign wb_stb_o  = (state_q == ST_BUS);
  assign wb_adr_o  = adr_q;
  assign f_valid_o = (state_q == ST_FULL);
  assign f_pkt_o   = slot_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= ST_IDLE;
      pc_q      <= `RV_RESET_PC;
      discard_q <= 1'b0;
    end else begin
      if (redirect_i.valid) begin
        pc_q <= redirect_i.target;
      end else if (keep) begin
        pc_q <= pc_q + 'd4;
      end
      case (state_q)
        ST_IDLE: begin
          if (start_bus) begin
            state_q <= ST_BUS;
          end
        end
        ST_BUS: begin
          if (wb_ack_i) begin
            discard_q <= 1'b0;
            state_q   <= keep ? ST_FULL : ST_IDLE;
          end else if (redirect_i.valid) begin
            discard_q <= 1'b1;
          end
        end
        ST_FULL: begin
          if (redirect_i.valid) begin
            state_q <= ST_IDLE;
          end else if (start_bus) begin
            state_q <= ST_BUS;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // the address is held for the whole bus cycle, even across a redirect.
  always_ff @(posedge clk) begin
    if (start_bus) begin
      adr_q <= pc_q;
    end
    if (keep) begin
      slot_q <= '{pc: adr_q, inst: wb_dat_i};
    end
  end

endmodule

`default_nettype wire

//--- rtl/rv_decode.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_decode (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      f_valid_i,
  input  rv_core_pkg::fetch_pkt_t  f_pkt_i,
  output logic                     f_ready_o,
  output logic [`RV_REG_AW-1:0]    rs1_o,
  output logic [`RV_REG_AW-1:0]    rs2_o,
  input  wire  [`RV_XLEN-1:0]      rdata1_i,
  input  wire  [`RV_XLEN-1:0]      rdata2_i,
  input  wire  [`RV_NUM_REGS-1:0]  busy_i,
  output logic                     set_busy_o,
  output logic [`RV_REG_AW-1:0]    set_busy_idx_o,
  input  rv_core_pkg::redirect_t   redirect_i,
  output logic                     d_valid_o,
  output rv_core_pkg::decode_pkt_t d_pkt_o
);
  import rv_core_pkg::*;

  logic                  full_q;
  logic [`RV_ILEN-1:0]   inst_q;
  logic [`RV_XLEN-1:0]   pc_q;
  opcode_e               opcode;
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_REG_AW-1:0] rd;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [`RV_XLEN-1:0]   imm_i;
  logic [`RV_XLEN-1:0]   imm_b;
  logic [`RV_XLEN-1:0]   imm_u;
  logic [`RV_XLEN-1:0]   imm_j;
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic                  stall;
  decode_pkt_t           pkt;

  // **************************************************************************
  // instruction buffer
  // **************************************************************************

  // execute never back-pressures, so the slot frees whenever it issues.
  assign f_ready_o = (!full_q || d_valid_o) && !redirect_i.valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= 1'b0;
    end else if (redirect_i.valid) begin
      full_q <= 1'b0;
    end else if (f_valid_i && f_ready_o) begin
      full_q <= 1'b1;
    end else if (d_valid_o) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (f_valid_i && f_ready_o) begin
      inst_q <= f_pkt_i.inst;
      pc_q   <= f_pkt_i.pc;
    end
  end

  // **************************************************************************
  // fields and immediates
  // **************************************************************************

  // only the low four bits of each register field are used on rv32e.
  assign opcode = opcode_e'(inst_q[6:0]);
  assign rd     = inst_q[7 +: `RV_REG_AW];
  assign rs1    = inst_q[15 +: `RV_REG_AW];
  assign rs2    = inst_q[20 +: `RV_REG_AW];
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  assign rs1_o = rs1;
  assign rs2_o = rs2;

  always_comb begin
    pkt         = '0;
    pkt.pc      = pc_q;
    pkt.rd      = rd;
    pkt.br_kind = funct3;
    pkt.alu_op  = ALU_ADD;
    uses_rs1    = 1'b0;
    uses_rs2    = 1'b0;
    case (opcode)
      OP_LUI: begin
        pkt.op2 = imm_u;
        pkt.wen = 1'b1;
      end
      OP_AUIPC: begin
        pkt.op1 = pc_q;
        pkt.op2 = imm_u;
        pkt.wen = 1'b1;
      end
      // jumps carry the link offset in op2 and the target base in op1.
      OP_JAL: begin
        pkt.op1     = pc_q;
        pkt.op2     = 'd4;
        pkt.imm     = imm_j;
        pkt.is_jump = 1'b1;
        pkt.wen     = 1'b1;
      end
      OP_JALR: begin
        pkt.op1     = rdata1_i;
        pkt.op2     = 'd4;
        pkt.imm     = imm_i;
        pkt.is_jump = 1'b1;
        pkt.wen     = 1'b1;
        uses_rs1    = 1'b1;
      end
      OP_BRANCH: begin
        pkt.op1       = rdata1_i;
        pkt.op2       = rdata2_i;
        pkt.imm       = imm_b;
        pkt.is_branch = 1'b1;
        uses_rs1      = 1'b1;
        uses_rs2      = 1'b1;
      end
      OP_IMM: begin
        pkt.op1    = rdata1_i;
        pkt.op2    = imm_i;
        pkt.alu_op = alu_op_e'({(funct3 == 3'b101) & funct7[5], funct3});
        pkt.wen    = 1'b1;
        uses_rs1   = 1'b1;
      end
      OP_REG: begin
        pkt.op1    = rdata1_i;
        pkt.op2    = rdata2_i;
        pkt.alu_op = alu_op_e'({funct7[5], funct3});
        pkt.wen    = 1'b1;
        uses_rs1   = 1'b1;
        uses_rs2   = 1'b1;
      end
      default: begin
        pkt.rd      = '0;
        pkt.illegal = 1'b1;
      end
    endcase
  end

  // a pending write to rd also holds issue, so an older write cannot clear a newer busy bit.
  assign stall = (uses_rs1 && busy_i[rs1]) || (uses_rs2 && busy_i[rs2]) ||
                 (pkt.wen && busy_i[rd]);

  assign d_valid_o      = full_q && !stall && !redirect_i.valid;
  assign d_pkt_o        = pkt;
  assign set_busy_o     = d_valid_o && pkt.wen && (rd != '0);
  assign set_busy_idx_o = rd;

endmodule

`default_nettype wire

//--- rtl/rv_execute.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_execute (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      d_valid_i,
  input  rv_core_pkg::decode_pkt_t d_pkt_i,
  output logic                     wr_en_o,
  output logic [`RV_REG_AW-1:0]    wr_idx_o,
  output logic [`RV_XLEN-1:0]      wr_data_o,
  output rv_core_pkg::redirect_t   redirect_o,
  output logic                     retire_valid_o,
  output rv_core_pkg::retire_t     retire_o
);
  import rv_core_pkg::*;

  logic [`RV_XLEN-1:0] op1;
  logic [`RV_XLEN-1:0] op2;
  logic [`RV_XLEN-1:0] alu_res;
  logic [`RV_XLEN-1:0] result;
  logic [`RV_XLEN-1:0] target;
  logic                cond;
  logic                taken;
  logic                redirect_q;
  logic [`RV_XLEN-1:0] target_q;

  assign op1 = d_pkt_i.op1;
  assign op2 = d_pkt_i.op2;

  always_comb begin
    case (d_pkt_i.alu_op)
      ALU_ADD:  alu_res = op1 + op2;
      ALU_SUB:  alu_res = op1 - op2;
      ALU_SLL:  alu_res = op1 << op2[4:0];
      ALU_SLT:  alu_res = {31'b0, $signed(op1) < $signed(op2)};
      ALU_SLTU: alu_res = {31'b0, op1 < op2};
      ALU_XOR:  alu_res = op1 ^ op2;
      ALU_SRL:  alu_res = op1 >> op2[4:0];
      ALU_SRA:  alu_res = $signed(op1) >>> op2[4:0];
      ALU_OR:   alu_res = op1 | op2;
      ALU_AND:  alu_res = op1 & op2;
      default:  alu_res = '0;
    endcase
  end

  // branch kind is funct3 of the branch.
  always_comb begin
    case (d_pkt_i.br_kind)
      3'b000:  cond = (op1 == op2);
      3'b001:  cond = (op1 != op2);
      3'b100:  cond = ($signed(op1) < $signed(op2));
      3'b101:  cond = ($signed(op1) >= $signed(op2));
      3'b110:  cond = (op1 < op2);
      3'b111:  cond = (op1 >= op2);
      default: cond = 1'b0;
    endcase
  end

  // branches and jal add to pc, jalr adds to rs1 which decode placed in op1.
  assign target = ((d_pkt_i.is_branch ? d_pkt_i.pc : op1) + d_pkt_i.imm) & ~32'd1;
  assign taken  = d_pkt_i.is_jump || (d_pkt_i.is_branch && cond);
  assign result = d_pkt_i.is_jump ? (d_pkt_i.pc + op2) : alu_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid_o <= 1'b0;
      wr_en_o        <= 1'b0;
      redirect_q     <= 1'b0;
    end else begin
      retire_valid_o <= d_valid_i;
      wr_en_o        <= d_valid_i && d_pkt_i.wen;
      redirect_q     <= d_valid_i && taken;
    end
  end

  always_ff @(posedge clk) begin
    if (d_valid_i) begin
      wr_idx_o  <= d_pkt_i.rd;
      wr_data_o <= result;
      target_q  <= target;
      retire_o  <= '{pc: d_pkt_i.pc, rd: d_pkt_i.rd, data: result,
                     wen: d_pkt_i.wen, illegal: d_pkt_i.illegal};
    end
  end

  assign redirect_o = '{valid: redirect_q, target: target_q};

endmodule

`default_nettype wire

//--- rtl/rv_regfile.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_regfile (
  input  wire                     clk,
  input  wire                     rst,
  input  wire  [`RV_REG_AW-1:0]   rs1_i,
  input  wire  [`RV_REG_AW-1:0]   rs2_i,
  output logic [`RV_XLEN-1:0]     rdata1_o,
  output logic [`RV_XLEN-1:0]     rdata2_o,
  input  wire                     wr_en_i,
  input  wire  [`RV_REG_AW-1:0]   wr_idx_i,
  input  wire  [`RV_XLEN-1:0]     wr_data_i,
  input  wire                     set_busy_i,
  input  wire  [`RV_REG_AW-1:0]   set_busy_idx_i,
  output logic [`RV_NUM_REGS-1:0] busy_o
);

  logic [`RV_XLEN-1:0]     regs [`RV_NUM_REGS];
  logic [`RV_NUM_REGS-1:0] busy_q;

  // x0 is never stored, reads of it are forced to zero.
  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

  always_ff @(posedge clk) begin
    if (wr_en_i && wr_idx_i != '0) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  // a set on the same index wins over the clear from write-back.
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      if (wr_en_i) begin
        busy_q[wr_idx_i] <= 1'b0;
      end
      if (set_busy_i) begin
        busy_q[set_busy_idx_i] <= 1'b1;
      end
    end
  end

  assign busy_o = busy_q & {{(`RV_NUM_REGS-1){1'b1}}, 1'b0};

endmodule

`default_nettype wire

//--- rtl/rv_core_top.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_core_top (
  input  wire                  clk,
  input  wire                  rst,
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output logic [`RV_XLEN-1:0]  wb_adr_o,
  input  wire  [`RV_XLEN-1:0]  wb_dat_i,
  input  wire                  wb_ack_i,
  output logic                 retire_valid_o,
  output rv_core_pkg::retire_t retire_o
);
  import rv_core_pkg::*;

  logic                    f_valid;
  logic                    f_ready;
  fetch_pkt_t              f_pkt;
  logic                    d_valid;
  decode_pkt_t             d_pkt;
  redirect_t               redirect;
  logic [`RV_REG_AW-1:0]   rs1;
  logic [`RV_REG_AW-1:0]   rs2;
  logic [`RV_XLEN-1:0]     rdata1;
  logic [`RV_XLEN-1:0]     rdata2;
  logic [`RV_NUM_REGS-1:0] busy;
  logic                    set_busy;
  logic [`RV_REG_AW-1:0]   set_busy_idx;
  logic                    wr_en;
  logic [`RV_REG_AW-1:0]   wr_idx;
  logic [`RV_XLEN-1:0]     wr_data;

  rv_fetch fetch0 (
    .clk        (clk),
    .rst        (rst),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_adr_o   (wb_adr_o),
    .wb_dat_i   (wb_dat_i),
    .wb_ack_i   (wb_ack_i),
    .redirect_i (redirect),
    .f_valid_o  (f_valid),
    .f_pkt_o    (f_pkt),
    .f_ready_i  (f_ready)
  );

  rv_decode decode0 (
    .clk            (clk),
    .rst            (rst),
    .f_valid_i      (f_valid),
    .f_pkt_i        (f_pkt),
    .f_ready_o      (f_ready),
    .rs1_o          (rs1),
    .rs2_o          (rs2),
    .rdata1_i       (rdata1),
    .rdata2_i       (rdata2),
    .busy_i         (busy),
    .set_busy_o     (set_busy),
    .set_busy_idx_o (set_busy_idx),
    .redirect_i     (redirect),
    .d_valid_o      (d_valid),
    .d_pkt_o        (d_pkt)
  );

  rv_execute execute0 (
    .clk            (clk),
    .rst            (rst),
    .d_valid_i      (d_valid),
    .d_pkt_i        (d_pkt),
    .wr_en_o        (wr_en),
    .wr_idx_o       (wr_idx),
    .wr_data_o      (wr_data),
    .redirect_o     (redirect),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  rv_regfile regfile0 (
    .clk            (clk),
    .rst            (rst),
    .rs1_i          (rs1),
    .rs2_i          (rs2),
    .rdata1_o       (rdata1),
    .rdata2_o       (rdata2),
    .wr_en_i        (wr_en),
    .wr_idx_i       (wr_idx),
    .wr_data_i      (wr_data),
    .set_busy_i     (set_busy),
    .set_busy_idx_i (set_busy_idx),
    .busy_o         (busy)
  );

endmodule

`default_nettype wire

//--- tests/rv_core_tb.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_core_tb;
  import rv_core_pkg::*;

  localparam int MEM_WORDS = 64;
  localparam int PROG_LEN  = 32;
  localparam int NUM_TESTS = 5;

  logic                clk;
  logic                rst;
  logic                wb_cyc;
  logic                wb_stb;
  logic [`RV_XLEN-1:0] wb_adr;
  logic [`RV_XLEN-1:0] wb_dat;
  logic                wb_ack;
  logic                retire_valid;
  retire_t             retire;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] xr [`RV_NUM_REGS];
  logic [31:0] mpc;
  logic [31:0] halt_addr;
  int          halt_hits;
  int          wp;
  int          wait_cnt;
  int          errors;
  int          checks;
  int          failed;
  int          tests_run;
  logic        first_cyc;
  logic        prev_stb;
  logic        prev_ack;
  logic [31:0] prev_adr;
  logic        rst_q;

  rv_core_top dut0 (
    .clk            (clk),
    .rst            (rst),
    .wb_cyc_o       (wb_cyc),
    .wb_stb_o       (wb_stb),
    .wb_adr_o       (wb_adr),
    .wb_dat_i       (wb_dat),
    .wb_ack_i       (wb_ack),
    .retire_valid_o (retire_valid),
    .retire_o       (retire)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ************************************************************************
  // instruction encoders
  // ************************************************************************

  function automatic logic [31:0] i_type(input logic [6:0] op, input int rd, input int f3,
                                         input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] op, input int rd, input int imm);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                         input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] j_type(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
  endfunction

  // ************************************************************************
  // reference ISA model
  // ************************************************************************

  function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic report(input string sig, input logic [31:0] got, input logic [31:0] exp);
    $display("ERROR %s: got %h expected %h at pc %h", sig, got, exp, mpc);
    errors++;
  endtask

  task automatic check_retire();
    logic [31:0] in;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ia;
    logic [31:0] res;
    logic [31:0] npc;
    logic [3:0]  rd;
    logic        wen;
    logic        ill;
    in  = mem[mpc[7:2]];
    a   = xr[in[18:15]];
    b   = xr[in[23:20]];
    ia  = {{20{in[31]}}, in[31:20]};
    rd  = in[10:7];
    wen = 1'b1;
    ill = 1'b0;
    res = '0;
    npc = mpc + 32'd4;
    case (in[6:0])
      7'h37: res = {in[31:12], 12'b0};
      7'h17: res = mpc + {in[31:12], 12'b0};
      7'h6f: begin
        res = mpc + 32'd4;
        npc = mpc + {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
      end
      7'h67: begin
        res = mpc + 32'd4;
        npc = (a + ia) & ~32'd1;
      end
      7'h63: begin
        wen = 1'b0;
        if (branch_taken(in[14:12], a, b)) begin
          npc = mpc + {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
        end
      end
      7'h13: res = alu(in[14:12], in[30] && (in[14:12] == 3'd5), a, ia);
      7'h33: res = alu(in[14:12], in[30], a, b);
      default: begin
        wen = 1'b0;
        ill = 1'b1;
      end
    endcase
    checks++;
    assert (retire.pc == mpc) else report("retire_o.pc", retire.pc, mpc);
    assert (retire.wen == wen) else report("retire_o.wen", 32'(retire.wen), 32'(wen));
    assert (retire.illegal == ill) else report("retire_o.illegal", 32'(retire.illegal), 32'(ill));
    if (wen) begin
      assert (retire.rd == rd) else report("retire_o.rd", 32'(retire.rd), 32'(rd));
      assert (retire.data == res) else report("retire_o.data", retire.data, res);
      if (rd != '0) begin
        xr[rd] = res;
      end
    end
    if (mpc == halt_addr) begin
      halt_hits++;
    end
    mpc = npc;
  endtask

  // ************************************************************************
  // monitors
  // ************************************************************************

  // reset is synchronous, so the outputs are cleared from the first edge that sees it.
  always @(posedge clk) begin
    rst_q = rst;
  end

  always @(negedge clk) begin
    if (rst_q) begin
      assert (!wb_cyc && !retire_valid) else begin
        $display("bus cycle or retire seen while reset is asserted");
        errors++;
      end
    end else if (!rst) begin
      if (retire_valid) begin
        check_retire();
      end
      if (first_cyc && wb_cyc) begin
        assert (wb_adr == `RV_RESET_PC) else report("wb_adr_o", wb_adr, `RV_RESET_PC);
        first_cyc = 1'b0;
      end
      if (prev_stb && !prev_ack) begin
        assert (wb_stb && wb_adr == prev_adr) else begin
          $display("wb_stb_o dropped or wb_adr_o changed before the ack");
          errors++;
        end
      end
    end
    prev_stb = wb_stb && !rst;
    prev_ack = wb_ack;
    prev_adr = wb_adr;
  end

  // memory slave with 0 to 3 wait cycles per access.
  always @(posedge clk) begin
    #1;
    if (rst) begin
      wb_ack   = 1'b0;
      wait_cnt = -1;
    end else if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (wait_cnt < 0) begin
        wait_cnt = int'($urandom_range(0, 3));
      end
      if (wait_cnt == 0) begin
        wb_ack   = 1'b1;
        wb_dat   = mem[wb_adr[7:2]];
        wait_cnt = -1;
      end else begin
        wait_cnt--;
      end
    end
  end

  initial begin
    repeat (40 * PROG_LEN * NUM_TESTS) @(posedge clk);
    $display("watchdog expired, the core stopped retiring the expected sequence");
    $display("=== FAIL ===");
    $finish;
  end

  // ************************************************************************
  // programs
  // ************************************************************************

  task automatic put(input logic [31:0] w);
    mem[wp] = w;
    wp++;
  endtask

  task automatic start_prog();
    for (int i = 0; i < MEM_WORDS; i++) begin
      // harmless writes to x0 that vary with the address.
      mem[i] = {i[19:0], 12'h013};
    end
    wp = 0;
  endtask

  task automatic put_halt();
    halt_addr = 32'(wp * 4);
    put(j_type(0, 0));
  endtask

  task automatic load_straight();
    start_prog();
    put(u_type(7'h37, 1, 32'h80000));
    put(i_type(7'h13, 2, 0, 0, -5));
    put(u_type(7'h17, 3, 32'h00012));
    put(i_type(7'h13, 4, 2, 2, 3));
    put(i_type(7'h13, 5, 3, 2, 3));
    put(i_type(7'h13, 6, 5, 1, 32'h404));
    put(i_type(7'h13, 7, 5, 1, 4));
    put(i_type(7'h13, 8, 1, 2, 3));
    put(i_type(7'h13, 9, 4, 2, 32'h0f0));
    put(i_type(7'h13, 10, 6, 2, 32'h30));
    put(i_type(7'h13, 11, 7, 2, 32'h7f));
    put(r_type(0, 2, 1, 0, 12));
    put(r_type(32'h20, 1, 2, 0, 13));
    put(r_type(0, 1, 2, 2, 14));
    put(r_type(0, 1, 2, 3, 15));
    put(r_type(32'h20, 2, 1, 5, 4));
    put(r_type(0, 2, 1, 5, 5));
    put(r_type(0, 2, 2, 1, 6));
    put(r_type(0, 9, 2, 4, 7));
    put(r_type(0, 9, 1, 6, 8));
    put(r_type(0, 9, 2, 7, 9));
    put_halt();
  endtask

  task automatic load_deps();
    start_prog();
    put(i_type(7'h13, 1, 0, 0, 1));
    put(i_type(7'h13, 1, 0, 1, 1));
    put(r_type(0, 1, 1, 0, 2));
    put(r_type(0, 1, 2, 0, 2));
    put(r_type(32'h20, 1, 2, 0, 3));
    put(i_type(7'h13, 0, 0, 0, 7));
    put(r_type(0, 2, 0, 0, 4));
    put(u_type(7'h37, 0, 1));
    put(r_type(0, 0, 0, 6, 5));
    put_halt();
  endtask

  task automatic load_flow();
    start_prog();
    put(i_type(7'h13, 1, 0, 0, 5));
    put(i_type(7'h13, 2, 0, 0, 5));
    put(b_type(0, 1, 2, 8));
    put(i_type(7'h13, 3, 0, 0, 99));
    put(b_type(1, 1, 2, 8));
    put(i_type(7'h13, 4, 0, 0, 1));
    put(i_type(7'h13, 5, 0, 0, -1));
    put(b_type(6, 0, 5, 8));
    put(i_type(7'h13, 6, 0, 0, 77));
    put(b_type(5, 5, 0, 8));
    put(j_type(7, 12));
    put(i_type(7'h13, 8, 0, 0, 11));
    put(i_type(7'h13, 9, 0, 0, 12));
    put(i_type(7'h13, 12, 0, 0, 3));
    // small backward loop, three passes.
    put(i_type(7'h13, 12, 0, 12, -1));
    put(b_type(1, 12, 0, -4));
    put(u_type(7'h17, 10, 0));
    put(i_type(7'h67, 11, 0, 10, 16));
    put(i_type(7'h13, 13, 0, 0, 55));
    put(i_type(7'h13, 14, 0, 0, 66));
    put_halt();
  endtask

  task automatic load_illegal();
    start_prog();
    put(i_type(7'h13, 15, 0, 0, 21));
    put(32'h1234_57ff);
    put(r_type(0, 0, 15, 0, 3));
    put(i_type(7'h13, 2, 0, 3, 4));
    put_halt();
  endtask

  task automatic run_test(input string name);
    int err_before;
    err_before = errors;
    @(posedge clk);
    #1;
    rst = 1'b1;
    mpc       = `RV_RESET_PC;
    halt_hits = 0;
    first_cyc = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    while (halt_hits < 2) begin
      @(posedge clk);
    end
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  initial begin
    void'($urandom(32'hcd106f26));
    rst       = 1'b1;
    rst_q     = 1'b0;
    wb_ack    = 1'b0;
    wb_dat    = '0;
    wait_cnt  = -1;
    errors    = 0;
    checks    = 0;
    failed    = 0;
    tests_run = 0;
    first_cyc = 1'b1;
    prev_stb  = 1'b0;
    prev_ack  = 1'b0;
    prev_adr  = '0;
    halt_addr = '1;
    mpc       = `RV_RESET_PC;
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      xr[i] = '0;
    end
    load_straight();
    run_test("straight line ALU");
    load_deps();
    run_test("dependencies and x0");
    load_flow();
    run_test("branches and jumps");
    load_illegal();
    run_test("illegal opcode");
    load_straight();
    run_test("straight line, new wait states");
    $display("tests %0d, failed %0d, retires checked %0d, errors %0d",
             tests_run, failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_core.f
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_regfile.sv
rtl/rv_core_top.sv
tests/rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module rv_core_tb \
  -f rv_core.f -o rv_core_sim

./obj_dir/rv_core_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
exit 0
